/* src.f */
source/harness_pkg.sv
source/dbg_ctrl.sv
source/bus_decoder.sv
source/boot_rom.sv
source/sram.sv
source/clint.sv
source/harness_top.sv
dv/harness_tb.sv

/* dv/harness_tb.sv */
/*
 * Harness testbench: clock and reset, bus master and debug stimulus,
 * reference models of the SRAM, ROM, CLINT and debug controller, and
 * the checking assertions
 */
`timescale 1ns/1ps

module harness_tb import harness_pkg::*; ();

  localparam int unsigned DmiDelCycles = 20;
  localparam int unsigned NumWords     = 1024;
  localparam int unsigned Seed         = 32'h5e5b_f485;
  localparam logic [31:0] RomWordBase  = 32'h0B00_7000;
  localparam int unsigned NumTestWords = 16;
  localparam int unsigned RspTimeout   = 10;
  localparam int unsigned TickCycles   = 6;

  logic     clk_i;
  logic     rst_ni;
  logic     rtc_i;
  logic     ndmreset_i;
  logic     debug_enable_i;
  logic     debug_req_i;
  bus_req_t bus_req_i;
  bus_rsp_t bus_rsp_o;
  logic     debug_req_o;
  logic     core_rst_no;
  logic     timer_irq_o;
  logic     ipi_o;

  // Reference model state
  logic [7:0]  shadow_mem [NumWords*BeWidth];
  bus_rsp_t    exp_rsp;
  data_t       cmp_model;
  logic        msip_model;
  logic        exp_irq;
  int unsigned tick_count;
  logic        ticking;
  int unsigned since_rst;
  int unsigned error_count;
  int unsigned timeout_count;

  always #4 clk_i = ~clk_i;

  harness_top #(
    .DmiDelCycles ( DmiDelCycles ),
    .NumWords     ( NumWords     )
  ) harness_top_inst (
    .clk_i          ( clk_i          ),
    .rst_ni         ( rst_ni         ),
    .rtc_i          ( rtc_i          ),
    .ndmreset_i     ( ndmreset_i     ),
    .debug_enable_i ( debug_enable_i ),
    .debug_req_i    ( debug_req_i    ),
    .bus_req_i      ( bus_req_i      ),
    .bus_rsp_o      ( bus_rsp_o      ),
    .debug_req_o    ( debug_req_o    ),
    .core_rst_no    ( core_rst_no    ),
    .timer_irq_o    ( timer_irq_o    ),
    .ipi_o          ( ipi_o          )
  );

  // ----------------------------------------------------------------------
  // Reference models
  // ----------------------------------------------------------------------
  function automatic logic hits(addr_t addr, addr_t base, addr_t length);
    return (addr >= base) && (addr < base + length);
  endfunction

  // First byte of the addressed SRAM word in the shadow
  function automatic int unsigned dram_byte(addr_t addr);
    return (((addr - DramBase) >> ByteOffset) % NumWords) * BeWidth;
  endfunction

  function automatic bus_rsp_t model_response(bus_req_t r);
    bus_rsp_t    rsp;
    addr_t       off;
    logic [31:0] rom_word;
    int unsigned first;
    rsp = '0;
    if (r.req) begin
      rsp.rvalid = 1'b1;
      off        = r.addr - ClintBase;
      rom_word   = RomWordBase + 32'(r.addr[5:3]);
      first      = dram_byte(r.addr);
      if (hits(r.addr, RomBase, RomLength)) begin
        if (r.we) begin
          rsp.err = 1'b1;
        end else begin
          rsp.rdata = {rom_word, rom_word};
        end
      end else if (hits(r.addr, ClintBase, ClintLength)) begin
        if (!r.we && off[31:3] == ClintMsipOffset[31:3]) begin
          rsp.rdata = data_t'(msip_model);
        end else if (!r.we && off[31:3] == ClintMtimecmpOffset[31:3]) begin
          rsp.rdata = cmp_model;
        end else if (!r.we && off[31:3] == ClintMtimeOffset[31:3]) begin
          rsp.rdata = data_t'(tick_count);
        end
      end else if (hits(r.addr, DramBase, DramLength)) begin
        if (!r.we) begin
          for (int i = 0; i < BeWidth; i++) begin
            rsp.rdata[i*8 +: 8] = shadow_mem[first + i];
          end
        end
      end else begin
        // GPIO and unmapped space
        rsp.err = 1'b1;
      end
    end
    return rsp;
  endfunction

  always @(posedge clk_i or negedge core_rst_no) begin
    if (!core_rst_no) begin
      exp_rsp    <= '0;
      cmp_model  <= '1;
      msip_model <= 1'b0;
      exp_irq    <= 1'b0;
    end else begin
      exp_rsp <= model_response(bus_req_i);
      exp_irq <= (data_t'(tick_count) >= cmp_model);
      if (bus_req_i.req && bus_req_i.we && hits(bus_req_i.addr, ClintBase, ClintLength)) begin
        if (bus_req_i.addr - ClintBase == ClintMsipOffset && bus_req_i.be[0]) begin
          msip_model <= bus_req_i.wdata[0];
        end
        if (bus_req_i.addr - ClintBase == ClintMtimecmpOffset) begin
          for (int i = 0; i < BeWidth; i++) begin
            if (bus_req_i.be[i]) cmp_model[i*8 +: 8] <= bus_req_i.wdata[i*8 +: 8];
          end
        end
      end
    end
  end

  // SRAM shadow has no reset, like the memory
  always @(posedge clk_i) begin
    if (bus_req_i.req && bus_req_i.we && hits(bus_req_i.addr, DramBase, DramLength)) begin
      for (int i = 0; i < BeWidth; i++) begin
        if (bus_req_i.be[i]) shadow_mem[dram_byte(bus_req_i.addr) + i] <= bus_req_i.wdata[i*8 +: 8];
      end
    end
  end

  // Cycles since the board reset released, saturating
  always @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      since_rst <= 0;
    end else if (since_rst < 1000) begin
      since_rst <= since_rst + 1;
    end
  end

  // ----------------------------------------------------------------------
  // Checks
  // ----------------------------------------------------------------------
  task automatic report_mismatch(string name, data_t exp_val, data_t got_val);
    error_count++;
    $display("FAILED at %0t: %s expected 0x%h, got 0x%h", $time, name, exp_val, got_val);
  endtask

  a_rvalid : assert property (@(posedge clk_i) disable iff (!core_rst_no)
    bus_rsp_o.rvalid == exp_rsp.rvalid)
    else report_mismatch("bus_rsp_o.rvalid", $sampled(exp_rsp.rvalid), $sampled(bus_rsp_o.rvalid));

  a_err : assert property (@(posedge clk_i) disable iff (!core_rst_no)
    bus_rsp_o.err == exp_rsp.err)
    else report_mismatch("bus_rsp_o.err", $sampled(exp_rsp.err), $sampled(bus_rsp_o.err));

  a_rdata : assert property (@(posedge clk_i) disable iff (!core_rst_no)
    bus_rsp_o.rdata === exp_rsp.rdata)
    else report_mismatch("bus_rsp_o.rdata", $sampled(exp_rsp.rdata), $sampled(bus_rsp_o.rdata));

  // Counter lags the rtc pin while a tick is in progress
  a_timer_irq : assert property (@(posedge clk_i) disable iff (!core_rst_no || ticking)
    timer_irq_o == exp_irq)
    else report_mismatch("timer_irq_o", $sampled(exp_irq), $sampled(timer_irq_o));

  a_ipi : assert property (@(posedge clk_i) disable iff (!core_rst_no)
    ipi_o == msip_model)
    else report_mismatch("ipi_o", $sampled(msip_model), $sampled(ipi_o));

  a_debug_gate : assert property (@(posedge clk_i) disable iff (!rst_ni)
    debug_req_o == ((since_rst >= DmiDelCycles) && debug_enable_i && debug_req_i))
    else report_mismatch("debug_req_o",
      $sampled((since_rst >= DmiDelCycles) && debug_enable_i && debug_req_i),
      $sampled(debug_req_o));

  a_core_rst : assert property (@(posedge clk_i) disable iff (!rst_ni)
    (since_rst >= 2) |-> (core_rst_no == !$past(ndmreset_i, 2)))
    else report_mismatch("core_rst_no", $sampled(!$past(ndmreset_i, 2)), $sampled(core_rst_no));

  // ----------------------------------------------------------------------
  // Stimulus
  // ----------------------------------------------------------------------
  task automatic step();
    @(posedge clk_i);
    #1;
  endtask

  task automatic wait_rsp();
    int unsigned n;
    n = 0;
    while (!bus_rsp_o.rvalid && n < RspTimeout) begin
      step();
      n++;
    end
    if (!bus_rsp_o.rvalid) begin
      timeout_count++;
      $display("Timeout at %0t: no bus response for address 0x%h", $time, bus_req_i.addr);
    end
  endtask

  // Leaves req high so the next access follows back to back
  task automatic bus_access(logic we, addr_t addr, be_t be, data_t wdata);
    bus_req_i.req   = 1'b1;
    bus_req_i.we    = we;
    bus_req_i.addr  = addr;
    bus_req_i.be    = be;
    bus_req_i.wdata = wdata;
    step();
    wait_rsp();
  endtask

  task automatic bus_idle();
    bus_req_i = '0;
    step();
  endtask

  task automatic wait_core_rst(logic level);
    int unsigned n;
    n = 0;
    while (core_rst_no !== level && n < 20) begin
      step();
      n++;
    end
    if (core_rst_no !== level) begin
      timeout_count++;
      $display("Timeout at %0t: core reset output never went to %b", $time, level);
    end
  endtask

  task automatic wait_gate_open();
    int unsigned n;
    n = 0;
    while (!debug_req_o && n < DmiDelCycles + 10) begin
      step();
      n++;
    end
    if (!debug_req_o) begin
      timeout_count++;
      $display("Timeout at %0t: debug request never passed the gate", $time);
    end
  endtask

  // Slow rtc pulse, long enough for the synchronizer
  task automatic rtc_tick();
    ticking = 1'b1;
    rtc_i   = 1'b1;
    repeat (TickCycles) step();
    tick_count++;
    rtc_i = 1'b0;
    repeat (TickCycles) step();
    ticking = 1'b0;
  endtask

  initial begin
    int unsigned widx;
    error_count    = 0;
    timeout_count  = 0;
    clk_i          = 1'b0;
    rst_ni         = 1'b0;
    rtc_i          = 1'b0;
    ndmreset_i     = 1'b0;
    debug_enable_i = 1'b1;
    debug_req_i    = 1'b1;
    bus_req_i      = '0;
    ticking        = 1'b0;
    tick_count     = 0;
    void'($urandom(Seed));

    repeat (10) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;
    wait_core_rst(1'b1);
    wait_gate_open();

    // SRAM fill, partial overwrites, read-back
    for (int i = 0; i < NumTestWords; i++) begin
      bus_access(1'b1, DramBase + 8 * i, '1, {$urandom, $urandom});
    end
    for (int i = 0; i < 2 * NumTestWords; i++) begin
      widx = $urandom % NumTestWords;
      bus_access(1'b1, DramBase + 8 * widx, be_t'($urandom), {$urandom, $urandom});
    end
    for (int i = 0; i < NumTestWords; i++) begin
      bus_access(1'b0, DramBase + 8 * i, '0, '0);
    end
    bus_idle();

    // ROM table, index wrap and error windows
    for (int i = 0; i < 8; i++) begin
      bus_access(1'b0, RomBase + 8 * i, '0, '0);
    end
    bus_access(1'b0, RomBase + 32'h58, '0, '0);
    bus_access(1'b1, RomBase, '1, 64'h1234);
    bus_access(1'b0, GpioBase + 32'h10, '0, '0);
    bus_access(1'b1, GpioBase, '1, 64'h55);
    bus_access(1'b0, 32'h2000_0000, '0, '0);
    bus_access(1'b0, 32'h0000_0100, '0, '0);
    bus_idle();

    // Timer, compare and software interrupt
    repeat (5) rtc_tick();
    bus_access(1'b0, ClintBase + ClintMtimeOffset, '0, '0);
    bus_access(1'b1, ClintBase + ClintMtimecmpOffset, '1, 64'd8);
    bus_access(1'b0, ClintBase + ClintMtimecmpOffset, '0, '0);
    bus_idle();
    repeat (3) rtc_tick();
    bus_access(1'b0, ClintBase + ClintMtimeOffset, '0, '0);
    bus_access(1'b1, ClintBase + ClintMsipOffset, 8'h01, 64'd1);
    bus_access(1'b0, ClintBase + ClintMsipOffset, '0, '0);
    bus_access(1'b1, ClintBase + ClintMsipOffset, 8'h01, 64'd0);
    bus_idle();

    // Debug enable masks the request
    debug_enable_i = 1'b0;
    repeat (5) step();
    debug_enable_i = 1'b1;
    debug_req_i    = 1'b0;
    step();
    debug_req_i = 1'b1;
    step();

    // Debug reset, SRAM must keep its contents
    ndmreset_i = 1'b1;
    wait_core_rst(1'b0);
    tick_count = 0;
    repeat (3) step();
    ndmreset_i = 1'b0;
    wait_core_rst(1'b1);
    bus_access(1'b0, ClintBase + ClintMtimecmpOffset, '0, '0);
    bus_access(1'b0, ClintBase + ClintMtimeOffset, '0, '0);
    for (int i = 0; i < NumTestWords; i++) begin
      bus_access(1'b0, DramBase + 8 * i, '0, '0);
    end
    bus_idle();
    repeat (4) step();

    $display("Errors: %0d failed checks, %0d timeouts", error_count, timeout_count);
    if (error_count == 0 && timeout_count == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

/* source/harness_top.sv */
/*
 * Harness top level: debug controller, bus decoder, boot ROM,
 * CLINT and SRAM
 */
`timescale 1ns/1ps

module harness_top import harness_pkg::*; #(
  parameter int unsigned DmiDelCycles = 500,
  parameter int unsigned NumWords     = 4096
) (
  input  logic     clk_i,
  input  logic     rst_ni,
  input  logic     rtc_i,
  input  logic     ndmreset_i,
  input  logic     debug_enable_i,
  input  logic     debug_req_i,
  input  bus_req_t bus_req_i,
  output bus_rsp_t bus_rsp_o,
  output logic     debug_req_o,
  output logic     core_rst_no,
  output logic     timer_irq_o,
  output logic     ipi_o
);

  bus_req_t rom_req;
  bus_req_t clint_req;
  bus_req_t dram_req;
  data_t    rom_rdata;
  data_t    clint_rdata;
  data_t    dram_rdata;

  dbg_ctrl #(
    .DmiDelCycles ( DmiDelCycles )
  ) i_dbg_ctrl (
    .clk_i          ( clk_i          ),
    .rst_ni         ( rst_ni         ),
    .ndmreset_i     ( ndmreset_i     ),
    .debug_enable_i ( debug_enable_i ),
    .debug_req_i    ( debug_req_i    ),
    .core_rst_no    ( core_rst_no    ),
    .debug_req_o    ( debug_req_o    )
  );

  // Decoder and CLINT follow the synchronized core reset
  bus_decoder i_bus_decoder (
    .clk_i         ( clk_i       ),
    .rst_ni        ( core_rst_no ),
    .bus_req_i     ( bus_req_i   ),
    .bus_rsp_o     ( bus_rsp_o   ),
    .rom_req_o     ( rom_req     ),
    .clint_req_o   ( clint_req   ),
    .dram_req_o    ( dram_req    ),
    .rom_rdata_i   ( rom_rdata   ),
    .clint_rdata_i ( clint_rdata ),
    .dram_rdata_i  ( dram_rdata  )
  );

  boot_rom i_boot_rom (
    .clk_i   ( clk_i     ),
    .req_i   ( rom_req   ),
    .rdata_o ( rom_rdata )
  );

  clint i_clint (
    .clk_i       ( clk_i       ),
    .rst_ni      ( core_rst_no ),
    .rtc_i       ( rtc_i       ),
    .req_i       ( clint_req   ),
    .rdata_o     ( clint_rdata ),
    .timer_irq_o ( timer_irq_o ),
    .ipi_o       ( ipi_o       )
  );

  sram #(
    .NumWords ( NumWords )
  ) i_sram (
    .clk_i   ( clk_i      ),
    .req_i   ( dram_req   ),
    .rdata_o ( dram_rdata )
  );

endmodule

/* source/clint.sv */
/*
 * Core-local interruptor: rtc synchronizer and edge detect, timer
 * counter, timer compare and software-interrupt registers
 */
`timescale 1ns/1ps

module clint import harness_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_ni,
  input  logic     rtc_i,
  input  bus_req_t req_i,
  output data_t    rdata_o,
  output logic     timer_irq_o,
  output logic     ipi_o
);

  logic [2:0]                      rtc_q;
  logic                            rtc_rise;
  addr_t                           offset;
  logic [AddrWidth-1:ByteOffset]   word_off;
  logic                            msip_sel;
  logic                            mtimecmp_sel;
  logic                            mtime_sel;
  logic                            wr_en;
  logic                            msip_q;
  data_t                           mtimecmp_q;
  data_t                           mtime_q;
  data_t                           rdata_q;
  logic                            timer_irq_q;

  // ----------------------------------------------------------------------
  // rtc tick
  // ----------------------------------------------------------------------
  // Two sync flops, third one for the edge
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rtc_q <= '0;
    end else begin
      rtc_q <= {rtc_q[1:0], rtc_i};
    end
  end

  assign rtc_rise = rtc_q[1] & ~rtc_q[2];

  // ----------------------------------------------------------------------
  // Register decode
  // ----------------------------------------------------------------------
  assign offset       = req_i.addr - ClintBase;
  assign word_off     = offset[AddrWidth-1:ByteOffset];
  assign msip_sel     = (word_off == ClintMsipOffset[AddrWidth-1:ByteOffset]);
  assign mtimecmp_sel = (word_off == ClintMtimecmpOffset[AddrWidth-1:ByteOffset]);
  assign mtime_sel    = (word_off == ClintMtimeOffset[AddrWidth-1:ByteOffset]);
  assign wr_en        = req_i.req && req_i.we;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      msip_q      <= 1'b0;
      mtimecmp_q  <= '1;
      mtime_q     <= '0;
      timer_irq_q <= 1'b0;
    end else begin
      if (wr_en && msip_sel && req_i.be[0]) begin
        msip_q <= req_i.wdata[0];
      end
      if (wr_en && mtimecmp_sel) begin
        mtimecmp_q <= apply_be(mtimecmp_q, req_i.wdata, req_i.be);
      end
      // Bus write wins over a tick
      if (wr_en && mtime_sel) begin
        mtime_q <= apply_be(mtime_q, req_i.wdata, req_i.be);
      end else if (rtc_rise) begin
        mtime_q <= mtime_q + 1'b1;
      end
      timer_irq_q <= (mtime_q >= mtimecmp_q);
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_i.req && !req_i.we) begin
      if (msip_sel) begin
        rdata_q <= data_t'(msip_q);
      end else if (mtimecmp_sel) begin
        rdata_q <= mtimecmp_q;
      end else if (mtime_sel) begin
        rdata_q <= mtime_q;
      end else begin
        rdata_q <= '0;
      end
    end
  end

  assign rdata_o     = rdata_q;
  assign timer_irq_o = timer_irq_q;
  assign ipi_o       = msip_q;

  // A write of bit zero shows up on ipi_o in the next cycle
  a_ipi_follows_msip : assert property (@(posedge clk_i) disable iff (!rst_ni)
    (wr_en && msip_sel && req_i.be[0]) |=> (ipi_o == $past(req_i.wdata[0])));

endmodule

/* source/sram.sv */
/*
 * Single-port SRAM with byte enables and one-cycle read,
 * no reset so contents survive a debug reset
 */
`timescale 1ns/1ps

module sram import harness_pkg::*; #(
  parameter int unsigned NumWords = 4096
) (
  input  logic     clk_i,
  input  bus_req_t req_i,
  output data_t    rdata_o
);

  localparam int unsigned IdxWidth = $clog2(NumWords);

  typedef logic [IdxWidth-1:0] idx_t;

  data_t mem_q [NumWords];
  idx_t  idx;
  data_t rdata_q;

  // Word index from the bits above the byte lanes, higher bits alias
  assign idx = req_i.addr[ByteOffset +: IdxWidth];

  always_ff @(posedge clk_i) begin
    if (req_i.req) begin
      if (req_i.we) begin
        mem_q[idx] <= apply_be(mem_q[idx], req_i.wdata, req_i.be);
      end else begin
        rdata_q <= mem_q[idx];
      end
    end
  end

  assign rdata_o = rdata_q;

endmodule

/* source/boot_rom.sv */
/*
 * Boot ROM: eight word table with a one-cycle registered read
 */
`timescale 1ns/1ps

module boot_rom import harness_pkg::*; (
  input  logic     clk_i,
  input  bus_req_t req_i,
  output data_t    rdata_o
);

  localparam int unsigned NumRomWords = 8;

  typedef logic [$clog2(NumRomWords)-1:0] rom_idx_t;

  // Both halves of word i hold 0x0B00_7000 + i
  localparam data_t RomTable [NumRomWords] = '{
    64'h0B00_7000_0B00_7000,
    64'h0B00_7001_0B00_7001,
    64'h0B00_7002_0B00_7002,
    64'h0B00_7003_0B00_7003,
    64'h0B00_7004_0B00_7004,
    64'h0B00_7005_0B00_7005,
    64'h0B00_7006_0B00_7006,
    64'h0B00_7007_0B00_7007
  };

  rom_idx_t idx;
  data_t    rdata_q;

  // Upper index bits wrap
  assign idx = req_i.addr[ByteOffset +: $clog2(NumRomWords)];

  always_ff @(posedge clk_i) begin
    if (req_i.req) begin
      rdata_q <= RomTable[idx];
    end
  end

  assign rdata_o = rdata_q;

endmodule

/* source/bus_decoder.sv */
/*
 * Bus decoder: address decode against the harness map, request routing
 * to ROM, CLINT and SRAM, error responder and response multiplexer
 */
`timescale 1ns/1ps

module bus_decoder import harness_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_ni,
  input  bus_req_t bus_req_i,
  output bus_rsp_t bus_rsp_o,
  output bus_req_t rom_req_o,
  output bus_req_t clint_req_o,
  output bus_req_t dram_req_o,
  input  data_t    rom_rdata_i,
  input  data_t    clint_rdata_i,
  input  data_t    dram_rdata_i
);

  target_e tgt_d;
  target_e tgt_q;
  logic    req_q;
  logic    we_q;

  function automatic logic in_window(addr_t addr, addr_t base, addr_t length);
    return (addr >= base) && ((addr - base) < length);
  endfunction

  // ----------------------------------------------------------------------
  // Decode and routing
  // ----------------------------------------------------------------------
  // GPIO and unmapped addresses keep the error target
  always_comb begin
    tgt_d = TGT_ERR;
    if (in_window(bus_req_i.addr, RomBase, RomLength)) begin
      // ROM is read only
      tgt_d = bus_req_i.we ? TGT_ERR : TGT_ROM;
    end else if (in_window(bus_req_i.addr, ClintBase, ClintLength)) begin
      tgt_d = TGT_CLINT;
    end else if (in_window(bus_req_i.addr, DramBase, DramLength)) begin
      tgt_d = TGT_DRAM;
    end
  end

  always_comb begin
    rom_req_o       = bus_req_i;
    clint_req_o     = bus_req_i;
    dram_req_o      = bus_req_i;
    rom_req_o.req   = bus_req_i.req && (tgt_d == TGT_ROM);
    clint_req_o.req = bus_req_i.req && (tgt_d == TGT_CLINT);
    dram_req_o.req  = bus_req_i.req && (tgt_d == TGT_DRAM);
  end

  // ----------------------------------------------------------------------
  // Response
  // ----------------------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      req_q <= 1'b0;
      we_q  <= 1'b0;
      tgt_q <= TGT_ERR;
    end else begin
      req_q <= bus_req_i.req;
      if (bus_req_i.req) begin
        we_q  <= bus_req_i.we;
        tgt_q <= tgt_d;
      end
    end
  end

  // Writes and errors return zero data
  always_comb begin
    bus_rsp_o.rvalid = req_q;
    bus_rsp_o.err    = req_q && (tgt_q == TGT_ERR);
    bus_rsp_o.rdata  = '0;
    if (req_q && !we_q) begin
      case (tgt_q)
        TGT_ROM:   bus_rsp_o.rdata = rom_rdata_i;
        TGT_CLINT: bus_rsp_o.rdata = clint_rdata_i;
        TGT_DRAM:  bus_rsp_o.rdata = dram_rdata_i;
        default:   bus_rsp_o.rdata = '0;
      endcase
    end
  end

  a_rsp_after_req : assert property (@(posedge clk_i) disable iff (!rst_ni)
    bus_rsp_o.rvalid |-> $past(bus_req_i.req));

endmodule

/* source/dbg_ctrl.sv */
/*
 * Debug controller: reset synchronizer for the combined board and
 * debug reset, and the boot window gate on debug requests
 */
`timescale 1ns/1ps

module dbg_ctrl #(
  parameter int unsigned DmiDelCycles = 500
) (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic ndmreset_i,
  input  logic debug_enable_i,
  input  logic debug_req_i,
  output logic core_rst_no,
  output logic debug_req_o
);

  localparam int unsigned CntWidth = (DmiDelCycles > 0) ? $clog2(DmiDelCycles + 1) : 1;

  logic [1:0]          rst_sync_q;
  logic [CntWidth-1:0] del_cnt_q;

  // Board reset asserts at once, ndmreset goes through both flops
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rst_sync_q <= 2'b00;
    end else begin
      rst_sync_q <= {rst_sync_q[0], ~ndmreset_i};
    end
  end

  assign core_rst_no = rst_sync_q[1];

  // Boot window, only the board reset reloads it
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      del_cnt_q <= CntWidth'(DmiDelCycles);
    end else if (del_cnt_q != '0) begin
      del_cnt_q <= del_cnt_q - 1'b1;
    end
  end

  assign debug_req_o = (del_cnt_q == '0) && debug_enable_i && debug_req_i;

  a_gate_closed : assert property (@(posedge clk_i) disable iff (!rst_ni)
    (del_cnt_q != '0) |-> !debug_req_o);

endmodule

/* source/harness_pkg.sv */
/*
 * Shared harness definitions: bus widths and their types, the address
 * map with the CLINT register offsets, the target select enum, the bus
 * request and response structs and a byte-enable merge helper
 */
package harness_pkg;

  // ----------------------------------------------------------------------
  // Bus widths
  // ----------------------------------------------------------------------
  localparam int unsigned AddrWidth  = 32;
  localparam int unsigned DataWidth  = 64;
  localparam int unsigned BeWidth    = DataWidth / 8;
  // Byte lanes inside one data word
  localparam int unsigned ByteOffset = $clog2(BeWidth);

  typedef logic [AddrWidth-1:0] addr_t;
  typedef logic [DataWidth-1:0] data_t;
  typedef logic [BeWidth-1:0]   be_t;

  // ----------------------------------------------------------------------
  // Address map
  // ----------------------------------------------------------------------
  localparam addr_t RomBase     = 32'h0001_0000;
  localparam addr_t RomLength   = 32'h0001_0000;
  localparam addr_t ClintBase   = 32'h0200_0000;
  localparam addr_t ClintLength = 32'h000C_0000;
  // GPIO is not implemented, the window only answers with an error
  localparam addr_t GpioBase    = 32'h4000_0000;
  localparam addr_t GpioLength  = 32'h0000_1000;
  localparam addr_t DramBase    = 32'h8000_0000;
  localparam addr_t DramLength  = 32'h1000_0000;

  // CLINT registers, relative to ClintBase
  localparam addr_t ClintMsipOffset     = 32'h0000_0000;
  localparam addr_t ClintMtimecmpOffset = 32'h0000_4000;
  localparam addr_t ClintMtimeOffset    = 32'h0000_BFF8;

  typedef enum logic [1:0] {
    TGT_ROM,
    TGT_CLINT,
    TGT_DRAM,
    TGT_ERR
  } target_e;

  // Plain strobe bus, answered one cycle later
  typedef struct packed {
    logic  req;
    logic  we;
    addr_t addr;
    be_t   be;
    data_t wdata;
  } bus_req_t;

  typedef struct packed {
    logic  rvalid;
    data_t rdata;
    logic  err;
  } bus_rsp_t;

  // Replace the enabled bytes of a word
  function automatic data_t apply_be(data_t old_data, data_t wdata, be_t be);
    data_t merged;
    merged = old_data;
    for (int unsigned i = 0; i < BeWidth; i++) begin
      if (be[i]) begin
        merged[i*8 +: 8] = wdata[i*8 +: 8];
      end
    end
    return merged;
  endfunction

endpackage
